//--- tb.f
hw/ldpcRegPkg.sv
hw/ldpcDataPkg.sv
hw/ldpcRegs.sv
hw/ldpcSyncDetect.sv
hw/ldpcDerand.sv
hw/ldpcOutputPacer.sv
hw/ldpcTop.sv
testbench/ldpcTop_chk.sv
testbench/ldpcTb.sv

//--- Makefile
SIM := obj_dir/VldpcTb

all: run

$(SIM): tb.f $(shell cat tb.f)
	verilator --binary --timing --assert -f tb.f --top-module ldpcTb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- testbench/ldpcTb.sv
module ldpcTb;
    import ldpcRegPkg::*;
    import ldpcDataPkg::*;

    logic        busClk;
    logic        rstN;
    logic        cs;
    logic        wr0;
    logic        wr1;
    logic        wr2;
    logic        wr3;
    logic [12:0] addr;
    logic [31:0] dataIn;
    logic [31:0] dataOut;
    logic        inBit;
    logic        inBitValid;
    logic        ldpcReady;
    logic        outBit;
    logic        outEn;
    logic        overflow;
    codeRateE    codeRate;
    logic [15:0] inverseMeanMantissa;
    logic [2:0]  inverseMeanExponent;
    logic [31:0] dllCenterFreq;
    logic [4:0]  dllLoopGain;
    logic [7:0]  dllFeedbackDivider;
    integer      seed;
    int          outCount = 0;

    ldpcTop dut0 (.*);

    always #50 busClk = ~busClk;

    always @(posedge busClk) begin
        if (outEn) begin
            outCount <= outCount + 1; // Bits leaving the pacer.
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic busWrite(input logic [12:0] a, input logic [31:0] d, input logic [3:0] lanes);
        @(posedge busClk);
        cs                   <= 1'b1;
        {wr3, wr2, wr1, wr0} <= lanes;
        addr                 <= a;
        dataIn               <= d;
        @(posedge busClk);
        cs                   <= 1'b0;
        {wr3, wr2, wr1, wr0} <= 4'h0;
    endtask

    task automatic busRead(input logic [12:0] a, output logic [31:0] d);
        @(posedge busClk);
        cs   <= 1'b1;
        addr <= a;
        @(negedge busClk);
        d = dataOut; // Settled mid-cycle.
        @(posedge busClk);
        cs <= 1'b0;
    endtask

    task automatic checkReg(input logic [12:0] a, input logic [31:0] expected);
        logic [31:0] got;
        busRead(a, got);
        if (got !== expected) begin
            failRun($sformatf("ERR %0t: register %0d reads %h, expected %h",
                              $time, a, got, expected));
        end
    endtask

    task automatic compareOutput(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            failRun($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, expected));
        end
    endtask

    task automatic waitState(input syncStateE want);
        logic [31:0] st;
        logic [31:0] expected;
        int          tries;
        tries = 0;
        busRead(addrStatus, st);
        while (st[1:0] != want) begin
            tries++;
            if (tries > 16) begin
                failRun($sformatf("Timed out waiting for sync state %s", want.name()));
            end
            busRead(addrStatus, st);
        end
        // In sync only in locked and flywheel; the marker is always sent inverted.
        expected = {(want == locked || want == flywheel), 1'b1, 20'h0,
                    rotInverted, 6'h0, want};
        if (st !== expected) begin
            failRun($sformatf("ERR %0t: status reads %h, expected %h", $time, st, expected));
        end
    endtask

    // One channel bit per strobe, then idle clocks.
    task automatic sendBit(input logic b, input int idle);
        @(posedge busClk);
        inBit      <= b;
        inBitValid <= 1'b1;
        @(posedge busClk);
        inBitValid <= 1'b0;
        repeat (idle) @(posedge busClk);
    endtask

    task automatic sendFrame(input logic [31:0] flipMask);
        logic [31:0] mark;
        logic [31:0] r;
        mark = ~syncMarker ^ flipMask; // Whole frame is phase flipped.
        repeat (32) begin
            sendBit(mark[31], 6);
            mark = mark << 1;
        end
        for (int i = 0; i < frameBitsShort; i++) begin
            r = $random(seed);
            sendBit(~r[0], (i < 16) ? 0 : 6); // Short burst fills the FIFO.
        end
    endtask

    initial begin
        int idle;
        int cycles;
        seed                 = 32'hab91;
        busClk               = 1'b0;
        rstN                 = 1'b0;
        cs                   = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        addr                 = 13'h0;
        dataIn               = 32'h0;
        inBit                = 1'b0;
        inBitValid           = 1'b0;
        ldpcReady            = 1'b1;
        repeat (10) @(posedge busClk);
        rstN <= 1'b1;

        checkReg(addrControl, 32'h0);
        checkReg(addrInverseMean, 32'h0);
        checkReg(addrOutputClkDiv, 32'h0);
        checkReg(addrDllCenterFreq, 32'h0);
        checkReg(addrDllGains, 32'h0);
        busWrite(addrDllCenterFreq, 32'hA1B2C3D4, 4'b0100);
        checkReg(addrDllCenterFreq, 32'h00B20000);
        busWrite(addrDllCenterFreq, 32'h11223344, 4'b1111);
        checkReg(addrDllCenterFreq, 32'h11223344);
        busWrite(addrDllCenterFreq, 32'hFFFFFFFF, 4'b0001);
        checkReg(addrDllCenterFreq, 32'h112233FF);
        busWrite(addrDllGains, 32'hFFFFFFFF, 4'b0001);
        busWrite(addrDllFdbkDiv, 32'h00A50000, 4'b0100);
        checkReg(addrDllFdbkDiv, 32'h00A5001F);
        compareOutput("dllCenterFreq", dllCenterFreq, 32'h112233FF);
        compareOutput("dllLoopGain", dllLoopGain, 32'h1F);
        compareOutput("dllFeedbackDivider", dllFeedbackDivider, 32'hA5);
        busWrite(addrInverseMean, 32'hFFFDBEEF, 4'b0110);
        checkReg(addrInverseMean, 32'h0005BE00);
        compareOutput("inverseMeanMantissa", inverseMeanMantissa, 32'hBE00);
        compareOutput("inverseMeanExponent", inverseMeanExponent, 32'h5);
        busWrite(addrOutputClkDiv, 32'h00005503, 4'b0001);
        checkReg(addrOutputClkDiv, 32'h00000003);

        // Rate 2/3, CCSDS derandomizer, data inversion, threshold 2.
        busWrite(addrControl, 32'h80020091, 4'b0101);
        checkReg(addrControl, 32'h00020091);
        busWrite(addrControl, 32'h80020091, 4'b1111);
        checkReg(addrControl, 32'h80020091);
        compareOutput("codeRate", codeRate, rate23);

        sendFrame(32'h0);
        waitState(verify);
        sendFrame(32'h00000101); // Errors at the threshold.
        waitState(locked);
        sendFrame(32'h0);
        waitState(locked);
        sendFrame(32'h00FF0000);
        waitState(flywheel);
        sendFrame(32'h0);
        waitState(locked);
        sendFrame(32'h00FF0000);
        waitState(flywheel);
        sendFrame(32'h00FF0000);
        waitState(search);

        idle   = 0;
        cycles = 0;
        while (idle < 64) begin
            @(negedge busClk);
            idle = outEn ? 0 : idle + 1;
            cycles++;
            if (cycles > 5000) begin
                failRun("Timed out waiting for the output FIFO to drain");
            end
        end

        // Frames 2 to 6 arrive while in sync.
        if (outCount != 5 * frameBitsShort) begin
            failRun($sformatf("ERR %0t: %0d output bits, expected %0d",
                              $time, outCount, 5 * frameBitsShort));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- testbench/ldpcTop_chk.sv
module ldpcTopChk (
    input logic                     busClk,
    input logic                     rstN,
    input logic                     cs,
    input logic [12:0]              addr,
    input logic [31:0]              dataOut,
    input logic                     ldpcReady,
    input logic                     inBit,
    input logic                     inBitValid,
    input ldpcDataPkg::syncStateE   syncState,
    input logic                     inSync,
    input logic [1:0]               rotation,
    input logic                     dataValid,
    input logic                     frameStart,
    input logic                     invertData,
    input ldpcDataPkg::derandModeE  derandMode,
    input logic [15:0]              outputEnClkDiv,
    input logic                     outBit,
    input logic                     outEn,
    input logic                     overflow
);
    import ldpcRegPkg::*;
    import ldpcDataPkg::*;

    logic        lastIn;
    logic [7:0]  pnModel;
    logic [7:0]  pnNow;
    logic        expQ [0:63];
    logic [5:0]  wp;
    logic [5:0]  rp;
    logic [15:0] gap; // Cycles since the last outEn.

    // Oldest sequence bit in r[7]; taps from x^8+x^7+x^5+x^3+1.
    function automatic logic [7:0] pnStep(input logic [7:0] r);
        return {r[6:0], r[0] ^ r[2] ^ r[4] ^ r[7]};
    endfunction

    assign pnNow = frameStart ? pnSeed : pnModel;

    always @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            lastIn  <= 1'b0;
            pnModel <= pnSeed;
            wp      <= 6'h0;
            rp      <= 6'h0;
            gap     <= 16'hFFFF;
        end else begin
            if (inBitValid) begin
                lastIn <= inBit;
            end
            if (dataValid) begin
                expQ[wp] <= lastIn ^ (rotation == rotInverted) ^ invertData ^
                            ((derandMode == derandCcsds) && pnNow[7]);
                wp      <= wp + 6'd1;
                pnModel <= pnStep(pnNow);
            end
            if (outEn) begin
                rp <= rp + 6'd1;
            end
            gap <= outEn ? 16'd1 : ((gap == 16'hFFFF) ? gap : gap + 16'd1);
        end
    end

    statusWord: assert property (@(posedge busClk) disable iff (!rstN)
        (cs && addr == addrStatus) |-> (dataOut[31] == inSync && dataOut[30] == ldpcReady &&
        dataOut[9:8] == rotation && dataOut[1:0] == syncState &&
        (dataOut & 32'h3FFFFCFC) == 32'h0))
        else $error("status word does not match the sync detector");

    enterVerify: assert property (@(posedge busClk) disable iff (!rstN)
        (syncState == verify && $past(syncState) != verify) |-> $past(syncState) == search)
        else $error("verify entered from a state other than search");

    enterLocked: assert property (@(posedge busClk) disable iff (!rstN)
        (syncState == locked && $past(syncState) != locked) |->
        ($past(syncState) == verify || $past(syncState) == flywheel))
        else $error("locked entered without a verified marker");

    enterFlywheel: assert property (@(posedge busClk) disable iff (!rstN)
        (syncState == flywheel && $past(syncState) != flywheel) |-> $past(syncState) == locked)
        else $error("flywheel entered from a state other than locked");

    lockRotation: assert property (@(posedge busClk) disable iff (!rstN)
        syncState == locked |-> rotation == rotInverted)
        else $error("rotation is not inverted while locked");

    dataBitOut: assert property (@(posedge busClk) disable iff (!rstN)
        outEn |-> (rp != wp && outBit == expQ[rp]))
        else $error("output bit differs from the derandomized payload");

    pacing: assert property (@(posedge busClk) disable iff (!rstN)
        outEn |-> {1'b0, gap} >= {1'b0, outputEnClkDiv} + 17'd1)
        else $error("outEn pulses closer than the divider allows");

    noOverflow: assert property (@(posedge busClk) disable iff (!rstN) !overflow)
        else $error("output FIFO overflowed");

endmodule

bind ldpcTop ldpcTopChk chk0 (
    .busClk(busClk), .rstN(rstN), .cs(cs), .addr(addr), .dataOut(dataOut),
    .ldpcReady(ldpcReady), .inBit(inBit), .inBitValid(inBitValid),
    .syncState(syncState), .inSync(inSync), .rotation(rotation),
    .dataValid(dataValid), .frameStart(frameStart), .invertData(invertData),
    .derandMode(derandMode), .outputEnClkDiv(outputEnClkDiv),
    .outBit(outBit), .outEn(outEn), .overflow(overflow)
);

//--- hw/ldpcTop.sv
module ldpcTop (
    input  logic                  busClk,
    input  logic                  rstN,
    input  logic                  cs,
    input  logic                  wr0,
    input  logic                  wr1,
    input  logic                  wr2,
    input  logic                  wr3,
    input  logic [12:0]           addr,
    input  logic [31:0]           dataIn,
    output logic [31:0]           dataOut,
    input  logic                  inBit,
    input  logic                  inBitValid,
    input  logic                  ldpcReady,
    output logic                  outBit,
    output logic                  outEn,
    output logic                  overflow,
    output ldpcRegPkg::codeRateE  codeRate,
    output logic [15:0]           inverseMeanMantissa,
    output logic [2:0]            inverseMeanExponent,
    output logic [31:0]           dllCenterFreq,
    output logic [4:0]            dllLoopGain,
    output logic [7:0]            dllFeedbackDivider
);
    import ldpcDataPkg::*;

    logic        ldpcRun;
    logic [10:0] syncThreshold;
    logic        codeLength4096;
    derandModeE  derandMode;
    logic        invertData;
    logic [15:0] outputEnClkDiv;
    logic        inSync;
    syncStateE   syncState;
    logic [1:0]  rotation;
    logic        dataBit;
    logic        dataValid;
    logic        frameStart;
    logic        derandBit;
    logic        derandValid;

    // Port names match the internal nets.
    ldpcRegs regs0 (.*);

    ldpcSyncDetect sync0 (.*);

    ldpcDerand derand0 (.*);

    ldpcOutputPacer pacer0 (.*);

endmodule

//--- hw/ldpcOutputPacer.sv
module ldpcOutputPacer (
    input  logic        busClk,
    input  logic        rstN,
    input  logic        derandBit,
    input  logic        derandValid,
    input  logic [15:0] outputEnClkDiv,
    output logic        outBit,
    output logic        outEn,
    output logic        overflow
);
    logic [15:0] fifoMem;
    logic [3:0]  wrPtr;
    logic [3:0]  rdPtr;
    logic [4:0]  count;
    logic [15:0] divCnt;
    logic        full;
    logic        push;
    logic        pop;

    assign full = count[4]; // 16 entries held.
    assign push = derandValid && !full;
    assign pop  = (divCnt == 16'h0) && (count != 5'h0);

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            wrPtr    <= 4'h0;
            rdPtr    <= 4'h0;
            count    <= 5'h0;
            divCnt   <= 16'h0;
            outEn    <= 1'b0;
            overflow <= 1'b0;
        end else begin
            wrPtr    <= wrPtr + 4'(push);
            rdPtr    <= rdPtr + 4'(pop);
            count    <= count + 5'(push) - 5'(pop);
            outEn    <= pop;
            overflow <= overflow || (derandValid && full); // Sticky.
            if (pop) begin
                divCnt <= outputEnClkDiv;
            end else if (divCnt != 16'h0) begin
                divCnt <= divCnt - 16'h1;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (push) begin
            fifoMem[wrPtr] <= derandBit;
        end
        if (pop) begin
            outBit <= fifoMem[rdPtr];
        end
    end

endmodule

//--- hw/ldpcDerand.sv
module ldpcDerand (
    input  logic                     busClk,
    input  logic                     rstN,
    input  logic                     dataBit,
    input  logic                     dataValid,
    input  logic                     frameStart,
    input  logic [1:0]               rotation,
    input  ldpcDataPkg::derandModeE  derandMode,
    input  logic                     invertData,
    output logic                     derandBit,
    output logic                     derandValid
);
    import ldpcDataPkg::*;

    logic [7:0] pnReg;
    logic [7:0] pnCur;
    logic       pnBit;
    logic       flip;

    // Frame start uses the seed directly for its own bit.
    assign pnCur = frameStart ? pnSeed : pnReg;
    assign pnBit = pnCur[7];
    assign flip  = (rotation == rotInverted) ^ invertData ^
                   ((derandMode == derandCcsds) && pnBit);

    // x^8+x^7+x^5+x^3+1, MSB is the current output.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            pnReg <= pnSeed;
        end else if (dataValid) begin
            pnReg <= {pnCur[6:0], pnCur[7] ^ pnCur[4] ^ pnCur[2] ^ pnCur[0]};
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            derandValid <= 1'b0;
        end else begin
            derandValid <= dataValid;
        end
    end

    always_ff @(posedge busClk) begin
        if (dataValid) begin
            derandBit <= dataBit ^ flip;
        end
    end

endmodule

//--- hw/ldpcSyncDetect.sv
module ldpcSyncDetect (
    input  logic                    busClk,
    input  logic                    rstN,
    input  logic                    inBit,
    input  logic                    inBitValid,
    input  logic                    ldpcRun,
    input  logic [10:0]             syncThreshold,
    input  logic                    codeLength4096,
    output logic                    inSync,
    output ldpcDataPkg::syncStateE  syncState,
    output logic [1:0]              rotation,
    output logic                    dataBit,
    output logic                    dataValid,
    output logic                    frameStart
);
    import ldpcDataPkg::*;

    logic [31:0] window;
    logic [31:0] nextWindow;
    logic [5:0]  matchTrue;
    logic [5:0]  matchComp;
    logic [5:0]  errTrue;
    logic [5:0]  errComp;
    logic        hitTrue;
    logic        hitComp;
    logic        markerHit;
    logic [1:0]  hitRot;
    logic        inMarker; // High while the 32 marker bits pass.
    logic [12:0] bitCnt;
    logic [12:0] frameLen;
    logic        lastBit;
    logic        issueBit;

    assign nextWindow = {window[30:0], inBit};
    assign matchTrue  = 6'($countones(~(nextWindow ^ syncMarker)));
    assign matchComp  = 6'($countones(nextWindow ^ syncMarker));
    assign errTrue    = 6'd32 - matchTrue;
    assign errComp    = 6'd32 - matchComp;
    assign hitTrue    = {5'h0, errTrue} <= syncThreshold;
    assign hitComp    = {5'h0, errComp} <= syncThreshold;
    assign markerHit  = hitTrue || hitComp;
    assign hitRot     = (errTrue <= errComp) ? rotNormal : rotInverted; // Closer polarity wins.

    assign frameLen = codeLength4096 ? 13'(frameBitsLong) : 13'(frameBitsShort);
    assign lastBit  = inMarker ? (bitCnt == 13'd31) : (bitCnt == frameLen - 13'd1);
    assign inSync   = (syncState == locked) || (syncState == flywheel);
    assign issueBit = inBitValid && ldpcRun && inSync && !inMarker;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            window <= 32'h0;
        end else if (inBitValid) begin
            window <= nextWindow;
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            syncState <= search;
            rotation  <= rotNormal;
            inMarker  <= 1'b0;
            bitCnt    <= 13'h0;
        end else if (!ldpcRun) begin
            syncState <= search;
        end else if (inBitValid) begin
            if (syncState == search) begin
                if (markerHit) begin
                    syncState <= verify;
                    rotation  <= hitRot;
                    inMarker  <= 1'b0;
                    bitCnt    <= 13'h0;
                end
            end else if (lastBit) begin
                bitCnt   <= 13'h0;
                inMarker <= !inMarker;
                if (inMarker && markerHit) begin
                    syncState <= locked;
                    rotation  <= hitRot;
                end else if (inMarker) begin
                    syncState <= (syncState == locked) ? flywheel : search;
                end
            end else begin
                bitCnt <= bitCnt + 13'd1;
            end
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            dataValid  <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            dataValid  <= issueBit;
            frameStart <= issueBit && (bitCnt == 13'h0); // First data bit.
        end
    end

    always_ff @(posedge busClk) begin
        if (inBitValid) begin
            dataBit <= inBit;
        end
    end

endmodule

//--- hw/ldpcRegs.sv
module ldpcRegs (
    input  logic                     busClk,
    input  logic                     rstN,
    input  logic                     cs,
    input  logic                     wr0,
    input  logic                     wr1,
    input  logic                     wr2,
    input  logic                     wr3,
    input  logic [12:0]              addr,
    input  logic [31:0]              dataIn,
    input  logic                     inSync,
    input  ldpcDataPkg::syncStateE   syncState,
    input  logic [1:0]               rotation,
    input  logic                     ldpcReady,
    output logic [31:0]              dataOut,
    output logic                     codeLength4096,
    output ldpcRegPkg::codeRateE     codeRate,
    output ldpcDataPkg::derandModeE  derandMode,
    output logic [10:0]              syncThreshold,
    output logic [15:0]              inverseMeanMantissa,
    output logic [2:0]               inverseMeanExponent,
    output logic                     ldpcRun,
    output logic [15:0]              outputEnClkDiv,
    output logic                     invertData,
    output logic [31:0]              dllCenterFreq,
    output logic [4:0]               dllLoopGain,
    output logic [7:0]               dllFeedbackDivider
);
    import ldpcRegPkg::*;
    import ldpcDataPkg::*;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            codeRate                 <= rate12;
            codeLength4096           <= 1'b0;
            derandMode               <= derandOff;
            invertData               <= 1'b0;
            inverseMeanMantissa[7:0] <= 8'h0;
            outputEnClkDiv[7:0]      <= 8'h0;
            dllCenterFreq[7:0]       <= 8'h0;
            dllLoopGain              <= 5'h0;
        end else if (cs && wr0) begin
            case (addr)
                addrControl: begin
                    codeRate       <= codeRateE'(dataIn[1:0]);
                    codeLength4096 <= dataIn[3];
                    derandMode     <= derandModeE'(dataIn[5:4]);
                    invertData     <= dataIn[7];
                end
                addrInverseMean:   inverseMeanMantissa[7:0] <= dataIn[7:0];
                addrOutputClkDiv:  outputEnClkDiv[7:0]      <= dataIn[7:0];
                addrDllCenterFreq: dllCenterFreq[7:0]       <= dataIn[7:0];
                addrDllGains:      dllLoopGain              <= dataIn[4:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            inverseMeanMantissa[15:8] <= 8'h0;
            outputEnClkDiv[15:8]      <= 8'h0;
            dllCenterFreq[15:8]       <= 8'h0;
        end else if (cs && wr1) begin
            case (addr)
                addrInverseMean:   inverseMeanMantissa[15:8] <= dataIn[15:8];
                addrOutputClkDiv:  outputEnClkDiv[15:8]      <= dataIn[15:8];
                addrDllCenterFreq: dllCenterFreq[15:8]       <= dataIn[15:8];
                default: ;
            endcase
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            syncThreshold[7:0]   <= 8'h0;
            inverseMeanExponent  <= 3'h0;
            dllCenterFreq[23:16] <= 8'h0;
            dllFeedbackDivider   <= 8'h0;
        end else if (cs && wr2) begin
            case (addr)
                addrControl:       syncThreshold[7:0]   <= dataIn[23:16];
                addrInverseMean:   inverseMeanExponent  <= dataIn[18:16];
                addrDllCenterFreq: dllCenterFreq[23:16] <= dataIn[23:16];
                addrDllFdbkDiv:    dllFeedbackDivider   <= dataIn[23:16];
                default: ;
            endcase
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            syncThreshold[10:8]  <= 3'h0;
            ldpcRun              <= 1'b0;
            dllCenterFreq[31:24] <= 8'h0;
        end else if (cs && wr3) begin
            case (addr)
                addrControl: begin
                    syncThreshold[10:8] <= dataIn[26:24];
                    ldpcRun             <= dataIn[31];
                end
                addrDllCenterFreq: dllCenterFreq[31:24] <= dataIn[31:24];
                default: ;
            endcase
        end
    end

    always_comb begin
        dataOut = 32'h0; // Idle bus reads zero.
        if (cs) begin
            case (addr)
                addrControl:       dataOut = {ldpcRun, 4'h0, syncThreshold, 8'h0,
                                              invertData, 1'b0, derandMode,
                                              codeLength4096, 1'b0, codeRate};
                addrInverseMean:   dataOut = {13'h0, inverseMeanExponent, inverseMeanMantissa};
                addrOutputClkDiv:  dataOut = {16'h0, outputEnClkDiv};
                addrStatus:        dataOut = {inSync, ldpcReady, 14'h0,
                                              6'h0, rotation, 6'h0, syncState};
                addrDllCenterFreq: dataOut = dllCenterFreq;
                addrDllGains,
                addrDllFdbkDiv:    dataOut = {8'h0, dllFeedbackDivider, 11'h0, dllLoopGain};
                default:           dataOut = 32'h0;
            endcase
        end
    end

endmodule

//--- hw/ldpcDataPkg.sv
package ldpcDataPkg;

    typedef enum logic [1:0] {
        search   = 2'd0,
        verify   = 2'd1,
        locked   = 2'd2,
        flywheel = 2'd3
    } syncStateE;

    // Codes 2 and 3 behave as off.
    typedef enum logic [1:0] {
        derandOff   = 2'd0,
        derandCcsds = 2'd1
    } derandModeE;

    localparam logic [31:0] syncMarker = 32'h1ACFFC1D; // Attached sync marker.

    localparam int frameBitsShort = 2048;
    localparam int frameBitsLong  = 4096;

    localparam logic [1:0] rotNormal   = 2'd0;
    localparam logic [1:0] rotInverted = 2'd2; // 180-degree phase flip.

    localparam logic [7:0] pnSeed = 8'hFF;

endpackage

//--- hw/ldpcRegPkg.sv
package ldpcRegPkg;

    // Word offsets on the 13-bit register bus.
    localparam logic [12:0] addrControl       = 13'd0;
    localparam logic [12:0] addrInverseMean   = 13'd1;
    localparam logic [12:0] addrOutputClkDiv  = 13'd2;
    localparam logic [12:0] addrStatus        = 13'd3; // Read only.
    localparam logic [12:0] addrDllCenterFreq = 13'd4;
    localparam logic [12:0] addrDllGains      = 13'd5;
    localparam logic [12:0] addrDllFdbkDiv    = 13'd6;

    // Control word field, bits 1:0.
    typedef enum logic [1:0] {
        rate12       = 2'd0,
        rate23       = 2'd1,
        rate45       = 2'd2,
        rateReserved = 2'd3
    } codeRateE;

endpackage
